// File: Makefile
# Verilator build and run for the tank video pixel path

TOP := tbTankVideoTop
SRCS := $(wildcard src/*.sv sim/*.sv)

.PHONY: all run lint clean

all: run

# Build the simulation model
obj_dir/V$(TOP): compile.f $(SRCS)
	verilator --binary --timing --assert -f compile.f --top-module $(TOP)

# Run, show the output, pass only when the pass line appears
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

# Static checks on the RTL and testbench
lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: compile.f
src/vgaTimingPkg.sv
src/gamePkg.sv
src/videoTimingGen.sv
src/tankRenderer.sv
src/colorMapper.sv
src/tankVideoTop.sv
sim/tbTankVideoTop.sv

// File: sim/tbTankVideoTop.sv
// Testbench for the tank video pixel path
// Tracks the pixel position from the first falling vSync at the top ports,
// predicts every RGB and sync value with its own reference model and runs
// one frame per test in title, single-player and multiplayer modes
`timescale 1ns/1ps

module tbTankVideoTop;
    import vgaTimingPkg::*;
    import gamePkg::*;

    localparam int tankSize     = 16;
    localparam int framePixels  = hTotal * vTotal;
    localparam int vsyncTimeout = 2 * hTotal * vTotal;
    localparam int maxPrinted   = 20;

    // DUT inputs and outputs
    logic       clk;
    logic       rstN;
    gameMode_t  mode;
    coord_t     tank1X;
    coord_t     tank1Y;
    coord_t     tank2X;
    coord_t     tank2Y;
    logic [7:0] vgaR;
    logic [7:0] vgaG;
    logic [7:0] vgaB;
    logic       hSync;
    logic       vSync;

    // Bookkeeping
    integer seed;
    int     errCount;
    int     checkCount;
    int     testCount;
    int     printed;
    bit     timedOut;
    bit     tracking;
    logic   prevVs;
    int     px;
    int     py;
    coord_t ax;
    coord_t ay;
    coord_t bx;
    coord_t by;

    tankVideoTop #(
        .tankSize (tankSize)
    ) DUT (
        .clk    (clk),
        .rstN   (rstN),
        .mode   (mode),
        .tank1X (tank1X),
        .tank1Y (tank1Y),
        .tank2X (tank2X),
        .tank2Y (tank2Y),
        .vgaR   (vgaR),
        .vgaG   (vgaG),
        .vgaB   (vgaB),
        .hSync  (hSync),
        .vSync  (vSync)
    );

    // 8 ns clock
    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic colorCode_t refColor(input int x, input int y, input gameMode_t m,
                                            input int t1x, input int t1y,
                                            input int t2x, input int t2y);
        bit hit1;
        bit hit2;
        bit grid;
        hit1 = (x >= t1x) && (x < t1x + tankSize) && (y >= t1y) && (y < t1y + tankSize);
        hit2 = (x >= t2x) && (x < t2x + tankSize) && (y >= t2y) && (y < t2y + tankSize);
        grid = ((x % 32) == 0) || ((y % 32) == 0);
        // Porches and sync intervals are black
        if ((x >= hActive) || (y >= vActive))
            return blackColor;
        case (m)
            // Top three bits of a 10-bit x
            modeTitle:
                return barColors[x >> 7];
            modeSingle:
                return hit1 ? tank1Color : (grid ? gridColor : grassColor);
            modeMulti:
                return hit1 ? tank1Color : (hit2 ? tank2Color : blackColor);
            default:
                return blackColor;
        endcase
    endfunction

    // Random corner in [0, span)
    function automatic coord_t pickCoord(input int span);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return coord_t'(r % span);
    endfunction

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic checkRgb(input colorCode_t expCode, input logic [7:0] r,
                            input logic [7:0] g, input logic [7:0] b,
                            input int x, input int y);
        logic [7:0] expR;
        logic [7:0] expG;
        logic [7:0] expB;
        // Nibble repeated into both halves
        expR = {expCode[11:8], expCode[11:8]};
        expG = {expCode[7:4], expCode[7:4]};
        expB = {expCode[3:0], expCode[3:0]};
        if ((r !== expR) || (g !== expG) || (b !== expB))
        begin
            errCount++;
            if (printed < maxPrinted)
                $display("[FAIL] t=%0t RGB at x=%0d y=%0d is %02h%02h%02h, expected %02h%02h%02h",
                         $time, x, y, r, g, b, expR, expG, expB);
            printed++;
        end
    endtask

    task automatic checkSync(input logic expH, input logic expV, input logic gotH,
                             input logic gotV, input int x, input int y);
        if ((gotH !== expH) || (gotV !== expV))
        begin
            errCount++;
            if (printed < maxPrinted)
                $display("[FAIL] t=%0t syncs at x=%0d y=%0d are h=%b v=%b, expected h=%b v=%b",
                         $time, x, y, gotH, gotV, expH, expV);
            printed++;
        end
    endtask

    // --------------------------------------------------
    // Position tracker and comparing process
    // --------------------------------------------------
    // Outputs settle after the rising edge, sampled on the falling edge
    always @(negedge clk)
    begin
        if (rstN)
        begin
            if (!tracking)
            begin
                // First vSync fall is x=0 on the first sync line
                if (prevVs && !vSync)
                begin
                    tracking = 1'b1;
                    px = 0;
                    py = vActive + vFront;
                end
            end
            else
            begin
                px = px + 1;
                if (px == hTotal)
                begin
                    px = 0;
                    py = (py == vTotal - 1) ? 0 : py + 1;
                end
            end
            if (tracking)
            begin
                checkRgb(refColor(px, py, mode, int'(tank1X), int'(tank1Y),
                                  int'(tank2X), int'(tank2Y)),
                         vgaR, vgaG, vgaB, px, py);
                checkSync(!((px >= hActive + hFront) && (px < hActive + hFront + hSyncLen)),
                          !((py >= vActive + vFront) && (py < vActive + vFront + vSyncLen)),
                          hSync, vSync, px, py);
                checkCount++;
            end
            prevVs = vSync;
        end
    end

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    task automatic waitVsyncFall();
        int   cycles;
        logic prev;
        prev = vSync;
        for (cycles = 0; cycles < vsyncTimeout; cycles++)
        begin
            @(negedge clk);
            if (prev && !vSync)
                return;
            prev = vSync;
        end
        timedOut = 1'b1;
        $display("Timeout: vSync did not fall within %0d cycles", vsyncTimeout);
    endtask

    // Called 1 ns after a rising edge, just past a vSync fall
    task automatic runTest(input string name, input gameMode_t m, input coord_t t1x,
                           input coord_t t1y, input coord_t t2x, input coord_t t2y);
        int errStart;
        int chkStart;
        int errDelta;
        int chkDelta;
        mode     = m;
        tank1X   = t1x;
        tank1Y   = t1y;
        tank2X   = t2x;
        tank2Y   = t2y;
        errStart = errCount;
        chkStart = checkCount;
        waitVsyncFall();
        if (timedOut)
            return;
        @(posedge clk);
        #1;
        chkDelta = checkCount - chkStart;
        // Exactly one whole frame must have been compared
        if (chkDelta != framePixels)
        begin
            errCount++;
            $display("Test %s compared %0d pixels instead of one full frame of %0d",
                     name, chkDelta, framePixels);
        end
        errDelta = errCount - errStart;
        testCount++;
        $display("Test %0d %s: %0d checks, %0d mismatches", testCount, name, chkDelta, errDelta);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial
    begin
        seed       = 32'h4000f62e;
        rstN       = 1'b0;
        mode       = modeTitle;
        tank1X     = '0;
        tank1Y     = '0;
        tank2X     = '0;
        tank2Y     = '0;
        errCount   = 0;
        checkCount = 0;
        testCount  = 0;
        printed    = 0;
        timedOut   = 1'b0;
        tracking   = 1'b0;
        prevVs     = 1'b1;
        px         = 0;
        py         = 0;

        // Two cycles of reset, outputs checked in between
        @(posedge clk);
        @(negedge clk);
        checkRgb(blackColor, vgaR, vgaG, vgaB, 0, 0);
        checkSync(1'b1, 1'b1, hSync, vSync, 0, 0);
        testCount++;
        $display("Test %0d reset state: %0d mismatches", testCount, errCount);
        @(posedge clk);
        #1;
        rstN = 1'b1;

        // Line up with the first vertical sync
        waitVsyncFall();
        @(posedge clk);
        #1;

        ax = pickCoord(hActive - tankSize + 1);
        ay = pickCoord(vActive - tankSize + 1);
        bx = pickCoord(hActive - tankSize + 1);
        by = pickCoord(vActive - tankSize + 1);
        if (!timedOut)
            runTest("title bars", modeTitle, ax, ay, bx, by);
        if (!timedOut)
            runTest("single player", modeSingle, ax, ay, bx, by);
        if (!timedOut)
            runTest("multiplayer", modeMulti, ax, ay, bx, by);

        // Tank 2 offset by half a tank so the squares overlap
        ax = pickCoord(hActive - tankSize - 8);
        ay = pickCoord(vActive - tankSize - 8);
        if (!timedOut)
            runTest("multiplayer overlap", modeMulti, ax, ay, ax + coord_t'(8), ay + coord_t'(8));
        if (!timedOut)
            runTest("back to title", modeTitle, ax, ay, bx, by);

        $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
        if ((errCount == 0) && !timedOut)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: src/colorMapper.sv
// Colour mapper
// Expands the 12-bit colour code to 8 bits per channel by nibble
// repetition, zeroes the colour outside the visible area and registers
// it together with the syncs
`timescale 1ns/1ps

module colorMapper (
    input  logic                clk,
    input  logic                rstN,
    input  gamePkg::colorCode_t code,
    input  logic                hSyncD,
    input  logic                vSyncD,
    input  logic                blankD,
    output logic [7:0]          vgaR,
    output logic [7:0]          vgaG,
    output logic [7:0]          vgaB,
    output logic                hSync,
    output logic                vSync
);

    // 4 to 8 bits, F maps to FF and 0 to 00
    function automatic logic [7:0] expandNibble(input logic [3:0] nib);
        return {nib, nib};
    endfunction

    logic [7:0] redNext;
    logic [7:0] greenNext;
    logic [7:0] blueNext;

    // -----------------------------------------------
    // Palette and blanking
    // -----------------------------------------------
    always_comb
    begin
        redNext   = expandNibble(code[11:8]);
        greenNext = expandNibble(code[7:4]);
        blueNext  = expandNibble(code[3:0]);
        // Porches and sync must be black
        if (blankD)
        begin
            redNext   = 8'd0;
            greenNext = 8'd0;
            blueNext  = 8'd0;
        end
    end

    // -----------------------------------------------
    // Output registers
    // -----------------------------------------------
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            vgaR  <= 8'd0;
            vgaG  <= 8'd0;
            vgaB  <= 8'd0;
            hSync <= 1'b1;
            vSync <= 1'b1;
        end
        else
        begin
            vgaR  <= redNext;
            vgaG  <= greenNext;
            vgaB  <= blueNext;
            hSync <= hSyncD;
            vSync <= vSyncD;
        end
    end

    // Blank one cycle back means black now
    blankIsBlack: assert property (@(posedge clk) disable iff (!rstN)
        $past(blankD) |-> (vgaR == 8'd0) && (vgaG == 8'd0) && (vgaB == 8'd0))
        else $error("colour driven during blanking");

endmodule

// File: src/gamePkg.sv
// Game definitions for the tank video path
// Game modes, 12-bit colour codes and the per-pixel index rules
// for title bars and the grass grid
package gamePkg;

    // Mode encoding kept from the board firmware, 2'b11 unused
    typedef enum logic [1:0] {
        modeTitle  = 2'b00,
        modeSingle = 2'b01,
        modeMulti  = 2'b10
    } gameMode_t;

    // 4 bits per channel, R in [11:8], G in [7:4], B in [3:0]
    typedef logic [11:0] colorCode_t;

    // -----------------------------------------------
    // Fixed colour codes
    // -----------------------------------------------
    localparam colorCode_t tank1Color = 12'hF00;
    localparam colorCode_t tank2Color = 12'h00F;
    localparam colorCode_t grassColor = 12'h0A2;
    localparam colorCode_t gridColor  = 12'h060;
    localparam colorCode_t blackColor = 12'h000;

    // Title bars, left to right
    localparam colorCode_t barColors [0:7] = '{
        12'hFFF, 12'hFF0, 12'h0FF, 12'h0F0,
        12'hF0F, 12'hF00, 12'h00F, 12'h000
    };

    // -----------------------------------------------
    // Index rules
    // -----------------------------------------------
    // Bar index from the top three bits of x
    function automatic logic [2:0] barIndex(input vgaTimingPkg::coord_t x);
        return x[vgaTimingPkg::coordWidth-1 -: 3];
    endfunction

    // Grid line every 32 pixels on either axis
    function automatic logic onGrid(input vgaTimingPkg::coord_t x,
                                    input vgaTimingPkg::coord_t y);
        return (x[4:0] == 5'd0) || (y[4:0] == 5'd0);
    endfunction

endpackage

// File: src/tankRenderer.sv
// Tank renderer
// Picks one 12-bit colour code per pixel from the game mode, the two
// tank corners and the background rules, and delays the syncs and
// blank by the same one stage
`timescale 1ns/1ps

module tankRenderer #(
    parameter int tankSize = 16
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  vgaTimingPkg::coord_t drawX,
    input  vgaTimingPkg::coord_t drawY,
    input  logic                 hSync,
    input  logic                 vSync,
    input  logic                 blank,
    input  gamePkg::gameMode_t   mode,
    input  vgaTimingPkg::coord_t tank1X,
    input  vgaTimingPkg::coord_t tank1Y,
    input  vgaTimingPkg::coord_t tank2X,
    input  vgaTimingPkg::coord_t tank2Y,
    output gamePkg::colorCode_t  code,
    output logic                 hSyncD,
    output logic                 vSyncD,
    output logic                 blankD
);
    import vgaTimingPkg::*;
    import gamePkg::*;

    // One extra bit so corner plus size cannot wrap
    typedef logic [coordWidth:0] span_t;

    localparam span_t sizeExt = span_t'(tankSize);

    // -----------------------------------------------
    // Hit test
    // -----------------------------------------------
    // True when pos lies in [origin, origin + tankSize)
    function automatic logic inSpan(input coord_t pos, input coord_t origin);
        span_t posExt;
        span_t loExt;
        posExt = {1'b0, pos};
        loExt  = {1'b0, origin};
        return (posExt >= loExt) && (posExt < loExt + sizeExt);
    endfunction

    logic       onTank1;
    logic       onTank2;
    logic       onGridLine;
    colorCode_t codeNext;

    // Square tanks, both axes must hit
    assign onTank1    = inSpan(drawX, tank1X) && inSpan(drawY, tank1Y);
    assign onTank2    = inSpan(drawX, tank2X) && inSpan(drawY, tank2Y);
    assign onGridLine = onGrid(drawX, drawY);

    // -----------------------------------------------
    // Colour choice
    // -----------------------------------------------
    always_comb
    begin
        case (mode)
            // Vertical bars, x only
            modeTitle:
                codeNext = barColors[barIndex(drawX)];
            // One tank over the grass field
            modeSingle:
            begin
                if (onTank1)
                    codeNext = tank1Color;
                else if (onGridLine)
                    codeNext = gridColor;
                else
                    codeNext = grassColor;
            end
            // Tank 1 checked first so it covers tank 2
            modeMulti:
            begin
                if (onTank1)
                    codeNext = tank1Color;
                else if (onTank2)
                    codeNext = tank2Color;
                else
                    codeNext = blackColor;
            end
            default:
                codeNext = blackColor;
        endcase
    end

    // -----------------------------------------------
    // Output stage
    // -----------------------------------------------
    // Colour code, blanked downstream when not visible
    always_ff @(posedge clk)
    begin
        code <= codeNext;
    end

    // Syncs and blank travel with the code
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            hSyncD <= 1'b1;
            vSyncD <= 1'b1;
            blankD <= 1'b1;
        end
        else
        begin
            hSyncD <= hSync;
            vSyncD <= vSync;
            blankD <= blank;
        end
    end

    // Unused encoding 2'b11 must never arrive
    modeLegal: assert property (@(posedge clk) disable iff (!rstN)
        mode inside {modeTitle, modeSingle, modeMulti})
        else $error("illegal game mode %b", mode);

endmodule

// File: src/tankVideoTop.sv
// Tank video pixel path, top level
// Timing generator, tank renderer and colour mapper in a row, two
// register stages from coordinate to RGB
`timescale 1ns/1ps

module tankVideoTop #(
    parameter int tankSize = 16
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  gamePkg::gameMode_t   mode,
    input  vgaTimingPkg::coord_t tank1X,
    input  vgaTimingPkg::coord_t tank1Y,
    input  vgaTimingPkg::coord_t tank2X,
    input  vgaTimingPkg::coord_t tank2Y,
    output logic [7:0]           vgaR,
    output logic [7:0]           vgaG,
    output logic [7:0]           vgaB,
    output logic                 hSync,
    output logic                 vSync
);
    import vgaTimingPkg::*;
    import gamePkg::*;

    // Timing generator outputs
    coord_t drawX;
    coord_t drawY;
    logic   timHSync;
    logic   timVSync;
    logic   timBlank;

    // Renderer outputs, one stage later
    colorCode_t code;
    logic       hSyncD;
    logic       vSyncD;
    logic       blankD;

    // -----------------------------------------------
    // Pipeline
    // -----------------------------------------------
    videoTimingGen uTiming (
        .clk   (clk),
        .rstN  (rstN),
        .drawX (drawX),
        .drawY (drawY),
        .hSync (timHSync),
        .vSync (timVSync),
        .blank (timBlank)
    );

    tankRenderer #(
        .tankSize (tankSize)
    ) uRenderer (
        .clk    (clk),
        .rstN   (rstN),
        .drawX  (drawX),
        .drawY  (drawY),
        .hSync  (timHSync),
        .vSync  (timVSync),
        .blank  (timBlank),
        .mode   (mode),
        .tank1X (tank1X),
        .tank1Y (tank1Y),
        .tank2X (tank2X),
        .tank2Y (tank2Y),
        .code   (code),
        .hSyncD (hSyncD),
        .vSyncD (vSyncD),
        .blankD (blankD)
    );

    // Last stage, RGB lines up with its syncs
    colorMapper uMapper (
        .clk    (clk),
        .rstN   (rstN),
        .code   (code),
        .hSyncD (hSyncD),
        .vSyncD (vSyncD),
        .blankD (blankD),
        .vgaR   (vgaR),
        .vgaG   (vgaG),
        .vgaB   (vgaB),
        .hSync  (hSync),
        .vSync  (vSync)
    );

endmodule

// File: src/vgaTimingPkg.sv
// VGA timing definitions
// Horizontal and vertical intervals for 640x480 at one pixel per clock,
// plus the shared pixel coordinate type
package vgaTimingPkg;

    // -----------------------------------------------
    // Horizontal intervals, in pixel clocks
    // -----------------------------------------------
    // Visible pixels per line
    localparam int hActive  = 640;
    // Front porch before sync
    localparam int hFront   = 16;
    // Sync pulse, active low
    localparam int hSyncLen = 96;
    // Back porch after sync
    localparam int hBack    = 48;
    // Full line, 800 clocks
    localparam int hTotal   = hActive + hFront + hSyncLen + hBack;

    // -----------------------------------------------
    // Vertical intervals, in lines
    // -----------------------------------------------
    // Visible lines per frame
    localparam int vActive  = 480;
    localparam int vFront   = 10;
    // Two lines of vSync
    localparam int vSyncLen = 2;
    localparam int vBack    = 33;
    // Full frame, 525 lines
    localparam int vTotal   = vActive + vFront + vSyncLen + vBack;

    // -----------------------------------------------
    // Coordinates
    // -----------------------------------------------
    // Wide enough for both hTotal-1 and vTotal-1
    localparam int coordWidth = 10;

    typedef logic [coordWidth-1:0] coord_t;

endpackage

// File: src/videoTimingGen.sv
// VGA timing generator
// Pixel and line counters for 640x480, with registered active-low
// syncs and blank, all describing the count held in the same cycle
`timescale 1ns/1ps

module videoTimingGen (
    input  logic                 clk,
    input  logic                 rstN,
    output vgaTimingPkg::coord_t drawX,
    output vgaTimingPkg::coord_t drawY,
    output logic                 hSync,
    output logic                 vSync,
    output logic                 blank
);
    import vgaTimingPkg::*;

    // Sync windows, [start, end)
    localparam coord_t hSyncStart = coord_t'(hActive + hFront);
    localparam coord_t hSyncEnd   = coord_t'(hActive + hFront + hSyncLen);
    localparam coord_t vSyncStart = coord_t'(vActive + vFront);
    localparam coord_t vSyncEnd   = coord_t'(vActive + vFront + vSyncLen);
    localparam coord_t hLast      = coord_t'(hTotal - 1);
    localparam coord_t vLast      = coord_t'(vTotal - 1);

    coord_t hCount;
    coord_t vCount;
    coord_t hNext;
    coord_t vNext;

    // -----------------------------------------------
    // Next count
    // -----------------------------------------------
    always_comb
    begin
        hNext = hCount + coord_t'(1);
        vNext = vCount;
        // End of line, wrap and step the line counter
        if (hCount == hLast)
        begin
            hNext = '0;
            if (vCount == vLast)
                vNext = '0;
            else
                vNext = vCount + coord_t'(1);
        end
    end

    // -----------------------------------------------
    // Counters and decoded outputs
    // -----------------------------------------------
    // Decode from next count so outputs line up with the count register
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            hCount <= '0;
            vCount <= '0;
            hSync  <= 1'b1;
            vSync  <= 1'b1;
            blank  <= 1'b1;
        end
        else
        begin
            hCount <= hNext;
            vCount <= vNext;
            hSync  <= !((hNext >= hSyncStart) && (hNext < hSyncEnd));
            vSync  <= !((vNext >= vSyncStart) && (vNext < vSyncEnd));
            blank  <= (hNext >= coord_t'(hActive)) || (vNext >= coord_t'(vActive));
        end
    end

    assign drawX = hCount;
    assign drawY = vCount;

    // -----------------------------------------------
    // Checks
    // -----------------------------------------------
    hCountInRange: assert property (@(posedge clk) disable iff (!rstN)
        hCount < coord_t'(hTotal))
        else $error("horizontal count reached line length");

    // Pulse width, one fall to the next rise
    hSyncWidth: assert property (@(posedge clk) disable iff (!rstN)
        $fell(hSync) |-> ##hSyncLen $rose(hSync))
        else $error("hSync pulse width wrong");

endmodule
